// ==== scope_top.f ====
src/scope_cfg_pkg.sv
src/scope_types_pkg.sv
src/adc_sampler.sv
src/config_reader.sv
src/trigger_capture.sv
src/host_copy.sv
src/scope_top.sv
tests/tb_clock_gen.sv
tests/tb_scope_top.sv

// ==== Makefile ====
# Verilator build and run of the scope capture testbench

VERILATOR ?= verilator
TOP       ?= tb_scope_top
FILELIST  ?= scope_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_scope_top.sv ====
// table periods must exceed convt_end; ramp values stay unique only for runs under 4096 samples
module tb_scope_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int   n_rows    = 4;
  localparam int   max_per   = 299;                        // largest period in the table
  localparam int   depth     = scope_cfg_pkg::capture_depth;
  localparam int   adc_w     = scope_cfg_pkg::adc_width;
  localparam logic wave_ramp = 1'b0;
  localparam logic wave_rand = 1'b1;
  localparam scope_types_pkg::sample_t ramp_step = 12'd37; // odd, full 4096 cycle
  localparam int   watchdog_ns = n_rows * 2 * (depth + 10) * (max_per + 1) * 10 +
                                 n_rows * 2 * scope_cfg_pkg::config_refresh * 10;

  // ==========================================================================
  // stimulus table
  // ==========================================================================
  typedef struct packed {
    scope_types_pkg::period_t period;
    logic [15:0]              trigger;
    logic                     wave;
    logic                     reading;
    int                       writes;   // host writes per copy, 0 when blocked
  } row_t;

  row_t rows [n_rows] = '{
    '{18'd199, 16'hffff, wave_rand, 1'b0, 405},  // free run
    '{18'd249, 16'h0800, wave_ramp, 1'b0, 405},  // mid-scale crossing
    '{18'd199, 16'hffff, wave_rand, 1'b1, 0},    // host holds the buffer
    '{18'd299, 16'h0400, wave_ramp, 1'b0, 405}
  };

  logic                        CLOCK_50;
  logic                        hps_fpga_reset_n;
  logic [adc_w-1:0]            adc_bus;
  logic                        hold_n;
  logic                        convt;
  scope_types_pkg::mbox_addr_t mbox_addr;
  scope_types_pkg::mbox_word_u mbox_rdata;
  logic                        host_reading;
  scope_types_pkg::buf_addr_t  host_addr;
  logic                        host_write;
  scope_types_pkg::host_word_t host_wdata;
  logic                        host_busy;

  scope_types_pkg::mbox_word_u mbox_mem [16];     // host mailbox
  scope_types_pkg::sample_t    hist [$];          // every value put on the bus, in order
  scope_types_pkg::sample_t    copy_data [depth]; // last copy seen on the host port
  scope_types_pkg::sample_t    ramp_val = '0;
  scope_types_pkg::sample_t    next_val;
  logic cur_wave   = wave_ramp;
  logic convt_q    = 1'b0;
  logic hold_q     = 1'b1;
  logic timing_en  = 1'b0;   // period timing checked only once settled
  int   row_period = 0;
  int   errors     = 0;
  int   checks     = 0;
  int   cyc        = 0;      // edges since reset release
  int   last_rise  = -1;
  int   high_len   = 0;
  int   low_len    = 0;

  tb_clock_gen clk_gen (.CLOCK_50(CLOCK_50), .hps_fpga_reset_n(hps_fpga_reset_n));

  scope_top DUT (
    .CLOCK_50(CLOCK_50), .hps_fpga_reset_n(hps_fpga_reset_n),
    .adc_bus(adc_bus), .hold_n(hold_n), .convt(convt),
    .mbox_addr(mbox_addr), .mbox_rdata(mbox_rdata),
    .host_reading(host_reading), .host_addr(host_addr), .host_write(host_write),
    .host_wdata(host_wdata), .host_busy(host_busy)
  );

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic check_sample(input scope_types_pkg::sample_t got,
                              input scope_types_pkg::sample_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input scope_types_pkg::buf_addr_t got,
                            input scope_types_pkg::buf_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // board wiring, sample bit 11 sits on bus bit 0
  function automatic logic [adc_w-1:0] wire_order(input scope_types_pkg::sample_t v);
    logic [adc_w-1:0] w;
    for (int i = 0; i < adc_w; i++) begin
      w[i] = v[adc_w-1-i];
    end
    return w;
  endfunction

  // first recorded index from lo where the whole copy lines up, -1 if none
  function automatic int find_offset(input int lo);
    int k;
    for (int j = lo; j + depth <= hist.size(); j++) begin
      k = 0;
      while (k < depth && copy_data[k] == hist[j+k])
        k++;
      if (k == depth) return j;
    end
    return -1;
  endfunction

  // where a capture armed at index arm must start
  function automatic int first_start(input int arm, input logic [15:0] trig);
    scope_types_pkg::sample_t level;
    level = trig[adc_w-1:0];
    if (trig == scope_cfg_pkg::trigger_free_run) return arm;  // next sample
    for (int k = (arm > 0) ? arm : 1; k < hist.size(); k++) begin
      if (hist[k-1] < level && hist[k] > level) return k;     // strict both ways
    end
    return -1;
  endfunction

  // waits for host address 0, then takes words while host_write holds
  task automatic collect_copy(output int n);
    n = 0;
    @(posedge CLOCK_50);
    while (!(host_write && host_addr == '0))
      @(posedge CLOCK_50);
    while (host_write) begin
      if (n < depth) begin
        check_addr(host_addr, scope_types_pkg::buf_addr_t'(n), "host_addr");
        check_count(int'(host_wdata[15:adc_w]), 0, "host_wdata upper bits");
        copy_data[n] = host_wdata[adc_w-1:0];
      end
      n++;
      @(posedge CLOCK_50);
    end
  endtask

  // ==========================================================================
  // mailbox and adc models
  // ==========================================================================
  always @(posedge CLOCK_50) begin
    mbox_rdata <= mbox_mem[mbox_addr];  // one cycle read latency
  end

  // adc model, one new value per conversion
  initial begin
    void'($urandom(32'h00cd65cd));
    forever begin
      @(posedge CLOCK_50);
      convt_q <= convt;
      if (convt && !convt_q) begin        // new conversion started
        if (cur_wave == wave_rand) begin
          next_val = scope_types_pkg::sample_t'($urandom);
        end else begin
          ramp_val = ramp_val + ramp_step;
          next_val = ramp_val;
        end
        adc_bus <= wire_order(next_val);
        hist.push_back(next_val);
      end
    end
  end

  // strobe timing and busy flag, every cycle
  always @(posedge CLOCK_50) begin
    hold_q <= hold_n;
    if (hps_fpga_reset_n) begin
      cyc++;
      if (cyc <= int'(scope_cfg_pkg::convt_start) + 2) begin  // count not yet past start
        check_bit(convt, 1'b0, "convt after reset");
        check_bit(host_write, 1'b0, "host_write after reset");
        check_bit(host_busy, 1'b0, "host_busy after reset");
      end
      check_bit(host_busy, host_write, "host_busy against host_write");
      if (convt && !convt_q) begin
        if (timing_en && last_rise >= 0) begin
          check_count(cyc - last_rise, row_period + 1, "convt rise spacing");
        end
        last_rise = timing_en ? cyc : -1;
        high_len  = 1;
      end else if (convt) begin
        high_len++;
      end else if (convt_q && timing_en) begin
        check_count(high_len, int'(scope_cfg_pkg::convt_end - scope_cfg_pkg::convt_start) - 1,
                    "convt high cycles");
      end
      if (!hold_n && hold_q) begin
        low_len = 1;
      end else if (!hold_n) begin
        low_len++;
      end else if (!hold_q && timing_en) begin
        check_count(low_len, int'(scope_cfg_pkg::hold_low_cycles), "hold_n low cycles");
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns before the table was done", watchdog_ns);
    $display("%0d errors in %0d checks", errors, checks);
    $display("Test failed");
    $finish;
  end

  // ==========================================================================
  // table loop
  // ==========================================================================
  initial begin
    scope_types_pkg::mbox_word_u pw;
    scope_types_pkg::mbox_word_u tw;
    int n;
    int off;
    int idx_start;
    int last_end;
    int next_lo;
    int exp_first;
    adc_bus      <= '0;
    host_reading <= 1'b0;
    mbox_rdata   <= '0;
    for (int a = 0; a < 16; a++) begin
      mbox_mem[a] <= '0;
    end
    next_lo = 0;
    @(posedge hps_fpga_reset_n);
    for (int r = 0; r < n_rows; r++) begin
      @(posedge CLOCK_50);
      pw = '0;
      pw.period_view.period = rows[r].period;
      tw = '0;
      tw.trigger_view.trigger = rows[r].trigger;
      timing_en    <= 1'b0;
      cur_wave     <= rows[r].wave;
      host_reading <= rows[r].reading;
      mbox_mem[scope_cfg_pkg::mbox_addr_period]  <= pw;
      mbox_mem[scope_cfg_pkg::mbox_addr_trigger] <= tw;
      n = 0;
      repeat (2 * scope_cfg_pkg::config_refresh) begin  // two mailbox reads
        @(posedge CLOCK_50);
        n += int'(host_write);
      end
      row_period <= int'(rows[r].period);
      timing_en  <= 1'b1;
      @(negedge CLOCK_50);
      idx_start = hist.size();  // settings in force from here
      last_end  = idx_start - 1;
      if (rows[r].writes == 0) begin
        repeat ((depth + 10) * (int'(rows[r].period) + 1)) begin
          @(posedge CLOCK_50);
          n += int'(host_write);
        end
        check_count(n, rows[r].writes, "host writes while host_reading is high");
      end else begin
        off = -1;
        while (off < idx_start) begin   // skip copies of older captures
          collect_copy(n);
          check_count(n, rows[r].writes, "host writes in one copy");
          @(negedge CLOCK_50);
          off = find_offset(next_lo);
          if (off < 0) begin
            errors++;
            $display("copy at %0t ns matches no run of samples put on the bus", $time);
            break;
          end
          next_lo = off + 1;
          if (off < idx_start && off + depth - 1 > last_end) last_end = off + depth - 1;
        end
        if (off >= 0) begin
          exp_first = first_start(last_end + 1, rows[r].trigger);
          check_count(off, exp_first, "capture start index");
          if (exp_first >= 0) check_sample(copy_data[0], hist[exp_first], "first copied word");
        end
      end
    end
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
// 10 ns clock from time 0; reset released with a non-blocking write on the 10th rising edge
module tb_clock_gen (
  output logic CLOCK_50,
  output logic hps_fpga_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int reset_cycles = 10;

  initial begin
    CLOCK_50 = 1'b0;
    forever #5 CLOCK_50 = ~CLOCK_50;  // 10 ns period
  end

  initial begin
    hps_fpga_reset_n = 1'b0;
    repeat (reset_cycles) @(posedge CLOCK_50);
    hps_fpga_reset_n <= 1'b1;  // first counting edge is the next one
  end

endmodule

// ==== src/scope_top.sv ====
// single clock design on CLOCK_50; mailbox and host buffer are external memories of the host
module scope_top (
  input  logic                                CLOCK_50,
  input  logic                                hps_fpga_reset_n,
  // parallel adc
  input  logic [scope_cfg_pkg::adc_width-1:0] adc_bus,
  output logic                                hold_n,
  output logic                                convt,
  // host mailbox, read only
  output scope_types_pkg::mbox_addr_t         mbox_addr,
  input  scope_types_pkg::mbox_word_u         mbox_rdata,
  // host capture memory
  input  logic                                host_reading,
  output scope_types_pkg::buf_addr_t          host_addr,
  output logic                                host_write,
  output scope_types_pkg::host_word_t         host_wdata,
  output logic                                host_busy
);

  scope_types_pkg::period_t   sample_period;
  logic [15:0]                trigger_word;
  scope_types_pkg::sample_t   sample;
  logic                       sample_valid;
  logic                       capture_done;
  scope_types_pkg::buf_addr_t buf_rd_addr;
  scope_types_pkg::sample_t   buf_rd_data;

  // ==========================================================================
  // input side
  // ==========================================================================
  adc_sampler u_adc_sampler (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .sample_period    (sample_period),
    .adc_bus          (adc_bus),
    .hold_n           (hold_n),
    .convt            (convt),
    .sample           (sample),
    .sample_valid     (sample_valid)
  );

  config_reader u_config_reader (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .mbox_addr        (mbox_addr),
    .mbox_rdata       (mbox_rdata),
    .sample_period    (sample_period),
    .trigger_word     (trigger_word)
  );

  // trigger and capture buffer
  trigger_capture u_trigger_capture (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .sample           (sample),
    .sample_valid     (sample_valid),
    .trigger_word     (trigger_word),
    .capture_done     (capture_done),
    .buf_rd_addr      (buf_rd_addr),
    .buf_rd_data      (buf_rd_data)
  );

  // ==========================================================================
  // output side
  // ==========================================================================
  host_copy u_host_copy (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .capture_done     (capture_done),
    .host_reading     (host_reading),
    .buf_rd_addr      (buf_rd_addr),
    .buf_rd_data      (buf_rd_data),
    .host_addr        (host_addr),
    .host_write       (host_write),
    .host_wdata       (host_wdata),
    .host_busy        (host_busy)
  );

endmodule

// ==== src/host_copy.sv ====
// capture_done while host_reading is high is dropped; a started copy always runs to the end
module host_copy (
  input  logic                          CLOCK_50,
  input  logic                          hps_fpga_reset_n,
  input  logic                          capture_done,
  input  logic                          host_reading,  // host owns the buffer
  output scope_types_pkg::buf_addr_t    buf_rd_addr,
  input  scope_types_pkg::sample_t      buf_rd_data,
  output scope_types_pkg::buf_addr_t    host_addr,
  output logic                          host_write,
  output scope_types_pkg::host_word_t   host_wdata,
  output logic                          host_busy
);

  logic fetching;   // read address walking the buffer
  logic start;
  logic last_rd;    // final buffer index issued this cycle

  assign start   = capture_done && !host_reading && !fetching;
  assign last_rd = (buf_rd_addr ==
                    scope_types_pkg::buf_addr_t'(scope_cfg_pkg::capture_depth - 1));

  // ==========================================================================
  // copy sequencer, read one step ahead of the write
  // ==========================================================================
  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      fetching    <= 1'b0;
      buf_rd_addr <= '0;
      host_write  <= 1'b0;
      host_addr   <= '0;
    end else begin
      if (start) begin
        fetching    <= 1'b1;
        buf_rd_addr <= '0;
      end else if (fetching) begin
        if (last_rd) begin
          fetching <= 1'b0;
        end else begin
          buf_rd_addr <= buf_rd_addr + 1'b1;
        end
      end
      host_write <= fetching;     // data for this index is out next cycle
      host_addr  <= buf_rd_addr;
    end
  end

  // widen the sample, upper bits zero
  assign host_wdata = {{(scope_cfg_pkg::host_data_width - scope_cfg_pkg::adc_width){1'b0}},
                       buf_rd_data};
  assign host_busy  = host_write;

endmodule

// ==== src/trigger_capture.sv ====
// buffer reads beyond capture_depth return undefined data; the level compare is strict both ways
module trigger_capture (
  input  logic                          CLOCK_50,
  input  logic                          hps_fpga_reset_n,
  input  scope_types_pkg::sample_t      sample,
  input  logic                          sample_valid,
  input  logic [15:0]                   trigger_word,
  output logic                          capture_done,
  input  scope_types_pkg::buf_addr_t    buf_rd_addr,
  output scope_types_pkg::sample_t      buf_rd_data
);

  scope_types_pkg::sample_t   buf_mem [scope_cfg_pkg::capture_depth];  // capture buffer
  scope_types_pkg::sample_t   prev_sample;  // previous valid sample, for the crossing
  scope_types_pkg::sample_t   level;        // trigger level
  scope_types_pkg::buf_addr_t wr_addr;      // next index, back at 0 while armed
  logic                       capturing;    // disarmed while set
  logic                       free_run;
  logic                       crossing;
  logic                       start;
  logic                       wr_en;

  // ==========================================================================
  // trigger decision
  // ==========================================================================
  assign level    = trigger_word[scope_cfg_pkg::adc_width-1:0];
  assign free_run = (trigger_word == scope_cfg_pkg::trigger_free_run);
  assign crossing = (prev_sample < level) && (sample > level);  // rising through level
  assign start    = sample_valid && !capturing && (crossing || free_run);

  assign wr_en  = start || (sample_valid && capturing);

  // last write of the capture, same cycle as the write itself
  assign capture_done = sample_valid && capturing &&
                        (wr_addr == scope_types_pkg::buf_addr_t'(scope_cfg_pkg::capture_depth - 1));

  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      prev_sample <= '0;
      capturing   <= 1'b0;
      wr_addr     <= '0;
    end else begin
      if (sample_valid) begin
        prev_sample <= sample;
      end
      if (start) begin
        capturing <= 1'b1;
        wr_addr   <= scope_types_pkg::buf_addr_t'(1);
      end else if (capture_done) begin
        capturing <= 1'b0;  // rearmed from the next cycle
        wr_addr   <= '0;    // trigger sample lands at 0
      end else if (wr_en) begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // ==========================================================================
  // buffer, one write port and one registered read port
  // ==========================================================================
  always_ff @(posedge CLOCK_50) begin
    if (wr_en) begin
      buf_mem[wr_addr] <= sample;
    end
    buf_rd_data <= buf_mem[buf_rd_addr];  // one cycle read latency
  end

endmodule

// ==== src/config_reader.sv ====
// mailbox read data must arrive one cycle after the address; values refresh every 1024 cycles
module config_reader (
  input  logic                        CLOCK_50,
  input  logic                        hps_fpga_reset_n,
  output scope_types_pkg::mbox_addr_t mbox_addr,
  input  scope_types_pkg::mbox_word_u mbox_rdata,
  output scope_types_pkg::period_t    sample_period,
  output logic [15:0]                 trigger_word
);

  logic [$clog2(scope_cfg_pkg::config_refresh)-1:0] refresh_cnt;
  logic                                             refresh_tick;  // start of a read pair
  logic [2:0]                                       rd_seq;        // one-hot read steps

  assign refresh_tick = (int'(refresh_cnt) == scope_cfg_pkg::config_refresh - 1);

  // ==========================================================================
  // refresh timer and read sequencer
  // ==========================================================================
  // rd_seq[0]  address = period word
  // rd_seq[1]  address = trigger word, rdata = period word
  // rd_seq[2]  rdata = trigger word
  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      refresh_cnt <= '0;
      rd_seq      <= '0;
      mbox_addr   <= scope_cfg_pkg::mbox_addr_period;
    end else begin
      if (refresh_tick) begin
        refresh_cnt <= '0;
      end else begin
        refresh_cnt <= refresh_cnt + 1'b1;
      end
      rd_seq <= {rd_seq[1:0], refresh_tick};
      if (refresh_tick) begin
        mbox_addr <= scope_cfg_pkg::mbox_addr_period;
      end else if (rd_seq[0]) begin
        mbox_addr <= scope_cfg_pkg::mbox_addr_trigger;  // next word right behind
      end
    end
  end

  // decoded settings, held between refreshes
  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      sample_period <= scope_cfg_pkg::default_period;
      trigger_word  <= scope_cfg_pkg::trigger_free_run;  // free run until told otherwise
    end else begin
      if (rd_seq[1]) begin
        sample_period <= mbox_rdata.period_view.period;
      end
      if (rd_seq[2]) begin
        trigger_word <= mbox_rdata.trigger_view.trigger;
      end
    end
  end

endmodule

// ==== src/adc_sampler.sv ====
// adc bus must hold still while convt is high; a period shorter than convt_end cuts convt short
module adc_sampler (
  input  logic                                CLOCK_50,
  input  logic                                hps_fpga_reset_n,
  input  scope_types_pkg::period_t            sample_period,  // last count of a period
  input  logic [scope_cfg_pkg::adc_width-1:0] adc_bus,        // as wired, bit-reversed
  output logic                                hold_n,
  output logic                                convt,
  output scope_types_pkg::sample_t            sample,
  output logic                                sample_valid
);

  scope_types_pkg::period_t conv_cnt;    // position inside the sample period
  scope_types_pkg::sample_t bus_rev;     // adc bus put back in natural order
  logic                     convt_next;  // convt for the coming cycle
  logic                     convt_fall;  // edge where convt drops, conversion finished

  // board routes adc bit 0 to the top pin
  always_comb begin
    for (int i = 0; i < scope_cfg_pkg::adc_width; i++) begin
      bus_rev[i] = adc_bus[scope_cfg_pkg::adc_width-1-i];
    end
  end

  assign convt_next = (conv_cnt > scope_cfg_pkg::convt_start) &&
                      (conv_cnt < scope_cfg_pkg::convt_end);   // 141 cycles wide
  assign convt_fall = convt && !convt_next;

  // ==========================================================================
  // period counter and strobe shaping
  // ==========================================================================
  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      conv_cnt     <= '0;
      hold_n       <= 1'b0;  // count restarts at 0, so hold is asserted
      convt        <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      // >= so a period lowered mid-count wraps at once
      if (conv_cnt >= sample_period) begin
        conv_cnt <= '0;
      end else begin
        conv_cnt <= conv_cnt + 1'b1;
      end
      hold_n       <= (conv_cnt >= scope_cfg_pkg::hold_low_cycles);  // 142 cycles low
      convt        <= convt_next;
      sample_valid <= convt_fall;  // one cycle after the latch edge
    end
  end

  // result latch, taken on the convt falling edge
  always_ff @(posedge CLOCK_50) begin
    if (convt_fall) begin
      sample <= bus_rev;
    end
  end

endmodule

// ==== src/scope_types_pkg.sv ====
// widths derive from scope_cfg_pkg; the two mailbox views overlay the same 32-bit word
package scope_types_pkg;

  // one adc sample, natural bit order
  typedef logic [scope_cfg_pkg::adc_width-1:0] sample_t;

  // index into the capture buffer and the host buffer
  typedef logic [$clog2(scope_cfg_pkg::capture_depth)-1:0] buf_addr_t;

  typedef logic [scope_cfg_pkg::host_data_width-1:0] host_word_t;  // host memory word
  typedef logic [3:0] mbox_addr_t;                                 // 16-word mailbox
  typedef logic [scope_cfg_pkg::period_width-1:0] period_t;        // last count of a period

  // ==========================================================================
  // mailbox word, read either as a sample period or as a trigger word
  // ==========================================================================
  typedef union packed {
    struct packed {
      logic [scope_cfg_pkg::mbox_width-scope_cfg_pkg::period_width-1:0] pad;  // unused
      period_t                                                         period;
    } period_view;
    struct packed {
      logic [scope_cfg_pkg::mbox_width-17:0] pad;      // unused upper half
      logic [15:0]                           trigger;  // low bits carry the level
    } trigger_view;
  } mbox_word_u;

endpackage

// ==== src/scope_cfg_pkg.sv ====
// all timing counts are CLOCK_50 cycles; capture_depth must stay within a 9-bit buffer index
package scope_cfg_pkg;

  // ==========================================================================
  // data path widths
  // ==========================================================================
  localparam int adc_width       = 12;   // parallel adc resolution
  localparam int host_data_width = 16;   // host buffer word
  localparam int mbox_width      = 32;   // host mailbox word
  localparam int period_width    = 18;   // sample period counter

  // samples per capture, one host buffer fill
  localparam int capture_depth = 405;

  // ==========================================================================
  // conversion timing, counted from the start of each sample period
  // ==========================================================================
  localparam logic [period_width-1:0] hold_low_cycles = 18'd142;  // hold_n low below this
  localparam logic [period_width-1:0] convt_start     = 18'd20;   // convt rises after this
  localparam logic [period_width-1:0] convt_end       = 18'd162;  // convt falls here

  // period in force until the mailbox has been read once
  localparam logic [period_width-1:0] default_period = 18'd199;

  // ==========================================================================
  // host mailbox
  // ==========================================================================
  localparam logic [3:0] mbox_addr_period  = 4'd1;  // word holding the sample period
  localparam logic [3:0] mbox_addr_trigger = 4'd2;  // word holding the trigger word

  // trigger word with every bit set, capture without waiting for a crossing
  localparam logic [15:0] trigger_free_run = 16'hffff;

  // cycles between two mailbox read pairs
  localparam int config_refresh = 1024;

endpackage
